// ==== all.f ====
logic/vga_pkg.sv
logic/vga_timing.sv
logic/vga_regs.sv
logic/vga_fetch.sv
logic/vga_color.sv
logic/vga_top.sv
verif/vga_ram_model.sv
verif/vga_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the VGA testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module vga_tb -f all.f -o vga_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vga_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== verif/vga_tb.sv ====
`timescale 1ns/1ps

module vga_tb import vga_pkg::*; ();

    localparam int v_total    = 525;
    localparam int vs_end_row = 492;
    localparam int ram_base_v = 'h10000;
    localparam int font_base_v = 'h38000;

    localparam logic [5:0] ega_pal [16] = '{
        6'b000000, 6'b000010, 6'b001000, 6'b001010,
        6'b100000, 6'b100010, 6'b100100, 6'b101010,
        6'b010101, 6'b010111, 6'b011101, 6'b011111,
        6'b110101, 6'b110111, 6'b111101, 6'b111111
    };

    logic       I_vga_clk;
    logic       I_reset;
    logic       I_bus_stb;
    bus_req_t   bus_req;
    logic       bus_ack;
    logic [7:0] bus_rdata;
    ram_req_t   ram_req;
    logic [7:0] ram_dat;
    logic       hsync;
    logic       vsync;
    rgb_t       rgb;

    int         seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         cyc;
    int         rst_release_cyc;
    int         first_vs_fall;
    logic       vs_prev;
    logic       aborted;
    ram_adr_t   got_adr [$];
    ram_adr_t   exp_adr [$];
    logic [5:0] got_run [$];
    logic [5:0] exp_run [$];

    vga_top i_vga_top (
        .I_vga_clk(I_vga_clk),
        .I_reset  (I_reset),
        .I_bus_stb(I_bus_stb),
        .bus_req  (bus_req),
        .bus_ack  (bus_ack),
        .bus_rdata(bus_rdata),
        .ram_req  (ram_req),
        .ram_dat  (ram_dat),
        .hsync    (hsync),
        .vsync    (vsync),
        .rgb      (rgb)
    );

    vga_ram_model i_vga_ram_model (
        .I_vga_clk(I_vga_clk),
        .I_reset  (I_reset),
        .ram_req  (ram_req),
        .ram_dat  (ram_dat)
    );

    initial I_vga_clk = 1'b0;
    always #50 I_vga_clk = ~I_vga_clk;

    initial cyc = 0;
    always @(posedge I_vga_clk) cyc <= cyc + 1;

    // first vsync falling edge after reset
    initial begin
        first_vs_fall = -1;
        vs_prev = 1'b1;
    end
    always @(negedge I_vga_clk) begin
        if (!I_reset && vs_prev && !vsync && first_vs_fall < 0) begin
            first_vs_fall = cyc;
        end
        vs_prev = vsync;
    end

    // ends the run after a stuck wait
    initial begin
        aborted = 1'b0;
        @(posedge aborted);
        $display("Simulation failed");
        $finish;
    end

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        aborted = 1'b1;
        forever begin
            @(negedge I_vga_clk);
        end
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    endtask

    task automatic report_error(input string why);
        errors++;
        $display("error at %0t: %s", $time, why);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // sel 0 waits on hsync, sel 1 on vsync
    task automatic wait_level(input bit sel, input logic lvl, input int limit);
        int n;
        logic s;
        n = 0;
        s = sel ? vsync : hsync;
        while (s !== lvl) begin
            @(negedge I_vga_clk);
            n++;
            if (n > limit) begin
                abort_run(sel ? "vsync stuck" : "hsync stuck");
            end
            s = sel ? vsync : hsync;
        end
    endtask

    task automatic wait_hsync_fall();
        wait_level(1'b0, 1'b1, 2000);
        wait_level(1'b0, 1'b0, 2000);
    endtask

    // leaves at the hsync fall that lies inside the given row
    task automatic seek_row(input int row);
        int falls;
        wait_level(1'b1, 1'b0, 500000);
        wait_level(1'b1, 1'b1, 5000);
        falls = (row + v_total - vs_end_row) % v_total + 1;
        repeat (falls) wait_hsync_fall();
    endtask

    // requests and color runs from one hsync fall to the next
    task automatic capture_line();
        int n;
        logic hs_prev;
        logic [5:0] px;
        got_adr.delete();
        got_run.delete();
        n = 0;
        hs_prev = hsync;
        px = rgb;
        got_run.push_back(px);
        while (n < 2000) begin
            @(negedge I_vga_clk);
            n++;
            if (hs_prev && !hsync) begin
                break;
            end
            hs_prev = hsync;
            if (ram_req.req) begin
                got_adr.push_back(ram_req.adr);
            end
            px = rgb;
            if (px != got_run[$]) begin
                got_run.push_back(px);
            end
        end
        if (n >= 2000) begin
            abort_run("line capture saw no closing hsync edge");
        end
    endtask

    task automatic add_exp_run(input logic [5:0] v);
        if (exp_run.size() == 0 || exp_run[$] != v) begin
            exp_run.push_back(v);
        end
    endtask

    task automatic compare_adrs(input string name);
        if (got_adr.size() != exp_adr.size()) begin
            report_mismatch({name, " request count"}, got_adr.size(), exp_adr.size());
        end
        for (int i = 0; i < got_adr.size() && i < exp_adr.size(); i++) begin
            if (got_adr[i] != exp_adr[i]) begin
                report_mismatch({name, " ram_req.adr"}, got_adr[i], exp_adr[i]);
                break;
            end
        end
    endtask

    task automatic compare_runs(input string name);
        if (got_run.size() != exp_run.size()) begin
            report_mismatch({name, " rgb run count"}, got_run.size(), exp_run.size());
        end
        for (int i = 0; i < got_run.size() && i < exp_run.size(); i++) begin
            if (got_run[i] != exp_run[i]) begin
                report_mismatch({name, " rgb"}, got_run[i], exp_run[i]);
                break;
            end
        end
    endtask

    task automatic bus_access(input int adr, input logic [7:0] dat, input logic we,
                              output logic [7:0] rdat);
        @(posedge I_vga_clk);
        I_bus_stb <= 1'b1;
        bus_req   <= '{adr: 4'(adr), dat: dat, we: we};
        @(negedge I_vga_clk);
        if (bus_ack) begin
            report_error("bus_ack high in the strobe cycle");
        end
        @(posedge I_vga_clk);
        I_bus_stb <= 1'b0;
        @(negedge I_vga_clk);
        if (!bus_ack) begin
            report_error("bus_ack missing one cycle after the strobe");
        end
        rdat = bus_rdata;
        @(negedge I_vga_clk);
        if (bus_ack) begin
            report_error("bus_ack held longer than one cycle");
        end
    endtask

    task automatic bus_write(input int adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_access(adr, dat, 1'b1, unused);
    endtask

    task automatic expect_read(input int adr, input logic [7:0] exp);
        logic [7:0] d;
        bus_access(adr, 8'h00, 1'b0, d);
        if (d != exp) begin
            report_mismatch($sformatf("bus_rdata[%0d]", adr), d, exp);
        end
    endtask

    task automatic test_registers();
        int e0;
        e0 = errors;
        // outputs right after reset release
        if (hsync !== 1'b1) begin
            report_mismatch("hsync", hsync, 1);
        end
        if (vsync !== 1'b1) begin
            report_mismatch("vsync", vsync, 1);
        end
        if (rgb !== '0) begin
            report_mismatch("rgb", rgb, 0);
        end
        if (ram_req.req !== 1'b0) begin
            report_mismatch("ram_req.req", ram_req.req, 0);
        end
        if (bus_ack !== 1'b0) begin
            report_mismatch("bus_ack", bus_ack, 0);
        end
        expect_read(8, 8'h03);
        expect_read(0, 8'h00);
        expect_read(1, 8'h00);
        expect_read(2, 8'h02);
        // staging alone must not move the base
        bus_write(0, 8'h55);
        expect_read(0, 8'h00);
        bus_write(0, 8'h00);
        bus_write(1, 8'h00);
        bus_write(2, 8'h01);
        bus_write(3, 8'h00);
        bus_write(4, 8'h00);
        bus_write(5, 8'h80);
        bus_write(6, 8'h03);
        bus_write(7, 8'h00);
        expect_read(0, 8'h00);
        expect_read(1, 8'h00);
        expect_read(2, 8'h01);
        expect_read(3, 8'h00);
        expect_read(4, 8'h00);
        expect_read(5, 8'h80);
        expect_read(6, 8'h03);
        expect_read(7, 8'h00);
        finish_test("reset and registers", e0);
    endtask

    task automatic test_sync();
        int e0;
        int t0;
        int t1;
        int t2;
        e0 = errors;
        wait_hsync_fall();
        t0 = cyc;
        wait_level(1'b0, 1'b1, 2000);
        t1 = cyc;
        wait_level(1'b0, 1'b0, 2000);
        t2 = cyc;
        if (t1 - t0 != 96) report_mismatch("hsync low cycles", t1 - t0, 96);
        if (t2 - t0 != 800) report_mismatch("hsync period", t2 - t0, 800);
        wait_level(1'b1, 1'b1, 500000);
        wait_level(1'b1, 1'b0, 500000);
        t0 = cyc;
        wait_level(1'b1, 1'b1, 500000);
        t1 = cyc;
        wait_level(1'b1, 1'b0, 500000);
        t2 = cyc;
        if (t1 - t0 != 2 * 800) report_mismatch("vsync low cycles", t1 - t0, 1600);
        if (t2 - t0 != 525 * 800) report_mismatch("vsync period", t2 - t0, 420000);
        if (first_vs_fall - rst_release_cyc != 490 * 800) begin
            report_mismatch("first vsync fall", first_vs_fall - rst_release_cyc, 392000);
        end
        finish_test("sync", e0);
    endtask

    task automatic test_gfx_640();
        int e0;
        logic [7:0] b;
        ram_adr_t a;
        e0 = errors;
        bus_write(8, 8'h02);
        seek_row(5);
        capture_line();
        exp_adr.delete();
        exp_run.delete();
        add_exp_run(6'd0);
        for (int k = 0; k < 320; k++) begin
            a = ram_adr_t'(ram_base_v + 5 * 320 + k);
            exp_adr.push_back(a);
            b = i_vga_ram_model.read_byte(a);
            add_exp_run(ega_pal[b[7:4]]);
            add_exp_run(ega_pal[b[3:0]]);
        end
        add_exp_run(6'd0);
        compare_adrs("640 row 5");
        compare_runs("640 row 5");
        finish_test("640 mode", e0);
    endtask

    task automatic test_gfx_320();
        int e0;
        logic [7:0] b;
        e0 = errors;
        bus_write(8, 8'h03);
        seek_row(0);
        for (int row = 0; row < 3; row++) begin
            capture_line();
            exp_adr.delete();
            exp_run.delete();
            add_exp_run(6'd0);
            for (int k = 0; k < 320; k++) begin
                exp_adr.push_back(ram_adr_t'(ram_base_v + (row / 2) * 320 + k));
                b = i_vga_ram_model.read_byte(exp_adr[$]);
                add_exp_run(b[5:0]);
            end
            add_exp_run(6'd0);
            compare_adrs($sformatf("320 row %0d", row));
            compare_runs($sformatf("320 row %0d", row));
        end
        finish_test("320 mode", e0);
    endtask

    task automatic test_text();
        int e0;
        int row;
        int base;
        logic [7:0] ch;
        logic [7:0] attr;
        logic [7:0] glyph;
        ram_adr_t fa;
        e0 = errors;
        row = 19;
        // cells are 16 lines tall with 80 bytes per cell row
        base = ram_base_v + (row / 16) * 80;
        bus_write(8, 8'h01);
        seek_row(row);
        capture_line();
        exp_adr.delete();
        exp_run.delete();
        add_exp_run(6'd0);
        for (int c = 0; c < 40; c++) begin
            ch = i_vga_ram_model.read_byte(ram_adr_t'(base + 2 * c));
            attr = i_vga_ram_model.read_byte(ram_adr_t'(base + 2 * c + 1));
            fa = ram_adr_t'(font_base_v + int'(ch) * 8 + (row % 16) / 2);
            glyph = i_vga_ram_model.read_byte(fa);
            exp_adr.push_back(ram_adr_t'(base + 2 * c));
            exp_adr.push_back(ram_adr_t'(base + 2 * c + 1));
            exp_adr.push_back(fa);
            for (int p = 0; p < 16; p++) begin
                add_exp_run(glyph[7 - p / 2] ? ega_pal[attr[7:4]] : ega_pal[attr[3:0]]);
            end
        end
        add_exp_run(6'd0);
        compare_adrs("text row 19");
        compare_runs("text row 19");
        finish_test("text mode", e0);
    endtask

    task automatic test_off();
        int e0;
        int bad;
        e0 = errors;
        bad = 0;
        bus_write(8, 8'h00);
        wait_level(1'b1, 1'b0, 500000);
        wait_level(1'b1, 1'b1, 5000);
        repeat (525 * 800) begin
            @(negedge I_vga_clk);
            if (bad == 0 && ram_req.req) begin
                report_error("ram request in off mode");
                bad = 1;
            end
            if (bad == 0 && rgb != '0) begin
                report_mismatch("rgb", rgb, 0);
                bad = 1;
            end
        end
        finish_test("off mode", e0);
    endtask

    initial begin
        I_reset = 1'b1;
        I_bus_stb = 1'b0;
        bus_req = '0;
        seed = 84150;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int a = 0; a < 524288; a++) begin
            i_vga_ram_model.write_byte(ram_adr_t'(a), 8'($random(seed)));
        end
        repeat (16) @(posedge I_vga_clk);
        I_reset <= 1'b0;
        @(negedge I_vga_clk);
        rst_release_cyc = cyc;
        test_registers();
        test_sync();
        test_gfx_640();
        test_gfx_320();
        test_text();
        test_off();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/vga_ram_model.sv ====
`timescale 1ns/1ps

module vga_ram_model import vga_pkg::*; (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  ram_req_t   ram_req,
    output logic [7:0] ram_dat
);

    localparam int depth = 524288;

    logic [7:0] mem [0:depth-1];

    // preload access for the testbench
    task automatic write_byte(input ram_adr_t adr, input logic [7:0] dat);
        mem[adr] = dat;
    endtask

    function automatic logic [7:0] read_byte(input ram_adr_t adr);
        return mem[adr];
    endfunction

    // one cycle read latency, data held until the next request
    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            ram_dat <= 8'h00;
        end else if (ram_req.req) begin
            ram_dat <= mem[ram_req.adr];
        end
    end

endmodule

// ==== logic/vga_top.sv ====
`timescale 1ns/1ps

module vga_top import vga_pkg::*; #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33
) (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  logic       I_bus_stb,
    input  bus_req_t   bus_req,
    output logic       bus_ack,
    output logic [7:0] bus_rdata,
    output ram_req_t   ram_req,
    input  logic [7:0] ram_dat,
    output logic       hsync,
    output logic       vsync,
    output rgb_t       rgb
);

    beam_t      beam;
    ram_adr_t   ram_base;
    ram_adr_t   font_base;
    vga_mode_t  mode;
    logic [7:0] pix_byte;
    logic [7:0] glyph_bits;
    logic [7:0] cell_color;

    vga_timing #(
        .h_visible(h_visible), .h_front(h_front), .h_pulse(h_pulse), .h_back(h_back),
        .v_visible(v_visible), .v_front(v_front), .v_pulse(v_pulse), .v_back(v_back)
    ) i_vga_timing (
        .I_vga_clk(I_vga_clk),
        .I_reset  (I_reset),
        .beam     (beam),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    vga_regs i_vga_regs (
        .I_vga_clk(I_vga_clk),
        .I_reset  (I_reset),
        .I_bus_stb(I_bus_stb),
        .bus_req  (bus_req),
        .bus_ack  (bus_ack),
        .bus_rdata(bus_rdata),
        .ram_base (ram_base),
        .font_base(font_base),
        .mode     (mode)
    );

    vga_fetch #(
        .h_visible(h_visible), .h_front(h_front), .h_pulse(h_pulse), .h_back(h_back),
        .v_visible(v_visible), .v_front(v_front), .v_pulse(v_pulse), .v_back(v_back)
    ) i_vga_fetch (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .beam      (beam),
        .mode      (mode),
        .ram_base  (ram_base),
        .font_base (font_base),
        .ram_req   (ram_req),
        .ram_dat   (ram_dat),
        .pix_byte  (pix_byte),
        .glyph_bits(glyph_bits),
        .cell_color(cell_color)
    );

    vga_color i_vga_color (
        .I_vga_clk (I_vga_clk),
        .I_reset   (I_reset),
        .beam      (beam),
        .mode      (mode),
        .pix_byte  (pix_byte),
        .glyph_bits(glyph_bits),
        .cell_color(cell_color),
        .rgb       (rgb)
    );

endmodule

// ==== logic/vga_color.sv ====
`timescale 1ns/1ps

module vga_color import vga_pkg::*; (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  beam_t      beam,
    input  vga_mode_t  mode,
    input  logic [7:0] pix_byte,
    input  logic [7:0] glyph_bits,
    input  logic [7:0] cell_color,
    output rgb_t       rgb
);

    // default EGA palette
    function automatic rgb_t ega_color(input color_idx_t idx);
        case (idx)
            4'd0:    ega_color = rgb_t'(6'b000000);
            4'd1:    ega_color = rgb_t'(6'b000010);
            4'd2:    ega_color = rgb_t'(6'b001000);
            4'd3:    ega_color = rgb_t'(6'b001010);
            4'd4:    ega_color = rgb_t'(6'b100000);
            4'd5:    ega_color = rgb_t'(6'b100010);
            4'd6:    ega_color = rgb_t'(6'b100100);
            4'd7:    ega_color = rgb_t'(6'b101010);
            4'd8:    ega_color = rgb_t'(6'b010101);
            4'd9:    ega_color = rgb_t'(6'b010111);
            4'd10:   ega_color = rgb_t'(6'b011101);
            4'd11:   ega_color = rgb_t'(6'b011111);
            4'd12:   ega_color = rgb_t'(6'b110101);
            4'd13:   ega_color = rgb_t'(6'b110111);
            4'd14:   ega_color = rgb_t'(6'b111101);
            default: ega_color = rgb_t'(6'b111111);
        endcase
    endfunction

    color_idx_t idx;
    rgb_t       next_rgb;

    always_comb begin
        case (mode)
            // glyph bit 7 is the leftmost pixel
            mode_text_40: idx = glyph_bits[3'd7 - beam.col[3:1]] ? cell_color[7:4]
                                                                 : cell_color[3:0];
            default:      idx = beam.col[0] ? pix_byte[3:0] : pix_byte[7:4];
        endcase
        if (!(beam.col_visible && beam.row_visible) || mode == mode_off) begin
            next_rgb = '0;
        end else if (mode == mode_gfx_320) begin
            next_rgb = rgb_t'(pix_byte[5:0]);
        end else begin
            next_rgb = ega_color(idx);
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            rgb <= '0;
        end else begin
            rgb <= next_rgb;
        end
    end

endmodule

// ==== logic/vga_fetch.sv ====
`timescale 1ns/1ps

module vga_fetch import vga_pkg::*; #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33
) (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  beam_t      beam,
    input  vga_mode_t  mode,
    input  ram_adr_t   ram_base,
    input  ram_adr_t   font_base,
    output ram_req_t   ram_req,
    input  logic [7:0] ram_dat,
    output logic [7:0] pix_byte,
    output logic [7:0] glyph_bits,
    output logic [7:0] cell_color
);

    localparam int h_start    = h_front + h_pulse + h_back;
    localparam int v_total    = v_visible + v_front + v_pulse + v_back;
    localparam int gfx_pitch  = h_visible / 2;
    localparam int text_pitch = h_visible / 8;
    localparam int idx_w      = $clog2(gfx_pitch + 1);

    // first request this many columns ahead of the first visible column
    localparam int lead_640  = 4;
    localparam int lead_320  = 2;
    localparam int lead_text = 15;

    typedef enum logic [1:0] {
        fk_pix,
        fk_char,
        fk_color,
        fk_font
    } fetch_kind_t;

    ram_adr_t          line_adr;
    logic [idx_w-1:0]  byte_idx;
    col_t              win_start;
    col_t              win_ofs;
    logic              in_window;
    logic              fetch_now;
    fetch_kind_t       fetch_kind;
    ram_adr_t          fetch_adr;
    logic              req_on;
    ram_adr_t          req_adr;
    fetch_kind_t       req_kind;
    logic              req_q;
    fetch_kind_t       kind_q;
    logic [7:0]        char_byte;
    logic [7:0]        color_next;
    logic [7:0]        glyph_next;
    logic [7:0]        pix_next;

    always_comb begin
        case (mode)
            mode_text_40: win_start = col_t'(h_start - lead_text - 1);
            mode_gfx_640: win_start = col_t'(h_start - lead_640 - 1);
            default:      win_start = col_t'(h_start - lead_320 - 1);
        endcase
    end

    // wraps to a large value before the window opens
    assign win_ofs   = beam.col - win_start;
    assign in_window = beam.row_visible && (mode != mode_off) &&
                       (win_ofs < col_t'(h_visible));

    always_comb begin
        fetch_now  = 1'b0;
        fetch_kind = fk_pix;
        fetch_adr  = line_adr + ram_adr_t'(byte_idx);
        if (in_window) begin
            if (mode == mode_text_40) begin
                // char, color, font row within each 16 column cell
                case (win_ofs[3:0])
                    4'd0: begin
                        fetch_now  = 1'b1;
                        fetch_kind = fk_char;
                    end
                    4'd2: begin
                        fetch_now  = 1'b1;
                        fetch_kind = fk_color;
                    end
                    4'd4: begin
                        fetch_now  = 1'b1;
                        fetch_kind = fk_font;
                        fetch_adr  = font_base + ram_adr_t'({char_byte, beam.row[3:1]});
                    end
                    default: ;
                endcase
            end else begin
                fetch_now = !win_ofs[0];
            end
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            req_on   <= 1'b0;
            req_q    <= 1'b0;
            byte_idx <= '0;
        end else begin
            req_on <= fetch_now;
            req_q  <= req_on;
            if (beam.line_end) begin
                byte_idx <= '0;
            end else if (fetch_now && fetch_kind != fk_font) begin
                byte_idx <= byte_idx + idx_w'(1);
            end
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (fetch_now) begin
            req_adr  <= fetch_adr;
            req_kind <= fetch_kind;
        end
        kind_q <= req_kind;
    end

    assign ram_req = '{adr: req_adr, req: req_on};

    // line address, reloaded at frame start
    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            line_adr <= ram_base;
        end else if (beam.line_end) begin
            if (beam.row == row_t'(v_total - 1)) begin
                line_adr <= ram_base;
            end else if (beam.row_visible) begin
                case (mode)
                    mode_gfx_640: line_adr <= line_adr + ram_adr_t'(gfx_pitch);
                    mode_gfx_320: begin
                        if (beam.row[0]) begin
                            line_adr <= line_adr + ram_adr_t'(gfx_pitch);
                        end
                    end
                    mode_text_40: begin
                        if (beam.row[3:0] == 4'hf) begin
                            line_adr <= line_adr + ram_adr_t'(text_pitch);
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ram byte sampled two cycles after its request
    always_ff @(posedge I_vga_clk) begin
        if (req_q) begin
            case (kind_q)
                fk_pix: begin
                    if (mode == mode_gfx_640) begin
                        pix_next <= ram_dat;
                    end else begin
                        pix_byte <= ram_dat;
                    end
                end
                fk_char:  char_byte  <= ram_dat;
                fk_color: color_next <= ram_dat;
                default:  glyph_next <= ram_dat;
            endcase
        end
        // 640 mode runs one byte deeper
        if (mode == mode_gfx_640 && beam.col[0]) begin
            pix_byte <= pix_next;
        end
        // next cell takes over at the cell boundary
        if (mode == mode_text_40 && win_ofs[3:0] == 4'hf) begin
            glyph_bits <= glyph_next;
            cell_color <= color_next;
        end
    end

endmodule

// ==== logic/vga_regs.sv ====
`timescale 1ns/1ps

module vga_regs import vga_pkg::*; (
    input  logic       I_vga_clk,
    input  logic       I_reset,
    input  logic       I_bus_stb,
    input  bus_req_t   bus_req,
    output logic       bus_ack,
    output logic [7:0] bus_rdata,
    output ram_adr_t   ram_base,
    output ram_adr_t   font_base,
    output vga_mode_t  mode
);

    localparam ram_adr_t ram_base_init  = 19'h20000;
    localparam ram_adr_t font_base_init = 19'h40000;

    logic [23:0] staging;
    logic        wr_stb;
    logic        rd_stb;

    assign wr_stb = I_bus_stb && bus_req.we;
    assign rd_stb = I_bus_stb && !bus_req.we;

    // staging bytes shared by both base registers
    always_ff @(posedge I_vga_clk) begin
        if (wr_stb) begin
            case (bus_req.adr)
                4'd0, 4'd4: staging[7:0]   <= bus_req.dat;
                4'd1, 4'd5: staging[15:8]  <= bus_req.dat;
                4'd2, 4'd6: staging[23:16] <= bus_req.dat;
                default: ;
            endcase
        end
    end

    // base addresses only change on commit
    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            ram_base  <= ram_base_init;
            font_base <= font_base_init;
            mode      <= mode_gfx_320;
            bus_ack   <= 1'b0;
        end else begin
            bus_ack <= I_bus_stb;
            if (wr_stb) begin
                case (bus_req.adr)
                    4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6: ;
                    4'd3: ram_base  <= staging[18:0];
                    4'd7: font_base <= staging[18:0];
                    default: mode <= vga_mode_t'(bus_req.dat[1:0]);
                endcase
            end
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (rd_stb) begin
            case (bus_req.adr)
                4'd0: bus_rdata <= ram_base[7:0];
                4'd1: bus_rdata <= ram_base[15:8];
                4'd2: bus_rdata <= {5'b00000, ram_base[18:16]};
                4'd4: bus_rdata <= font_base[7:0];
                4'd5: bus_rdata <= font_base[15:8];
                4'd6: bus_rdata <= {5'b00000, font_base[18:16]};
                4'd3, 4'd7: bus_rdata <= 8'h00;
                default: bus_rdata <= {6'b000000, mode};
            endcase
        end
    end

endmodule

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing import vga_pkg::*; #(
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_pulse   = 96,
    parameter int h_back    = 48,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_pulse   = 2,
    parameter int v_back    = 33
) (
    input  logic  I_vga_clk,
    input  logic  I_reset,
    output beam_t beam,
    output logic  hsync,
    output logic  vsync
);

    localparam int h_start      = h_front + h_pulse + h_back;
    localparam int h_total      = h_start + h_visible;
    localparam int v_sync_start = v_visible + v_front;
    localparam int v_total      = v_sync_start + v_pulse + v_back;

    col_t col;
    row_t row;
    logic line_end;

    assign line_end = (col == col_t'(h_total - 1));

    // raster counters, line starts with front porch
    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            col <= '0;
            row <= '0;
        end else if (line_end) begin
            col <= '0;
            if (row == row_t'(v_total - 1)) begin
                row <= '0;
            end else begin
                row <= row + row_t'(1);
            end
        end else begin
            col <= col + col_t'(1);
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            hsync <= 1'b1;
        end else if (col == col_t'(h_front - 1)) begin
            hsync <= 1'b0;
        end else if (col == col_t'(h_front + h_pulse - 1)) begin
            hsync <= 1'b1;
        end
    end

    // vsync switches on line boundaries only
    always_ff @(posedge I_vga_clk) begin
        if (I_reset) begin
            vsync <= 1'b1;
        end else if (line_end) begin
            if (row == row_t'(v_sync_start - 1)) begin
                vsync <= 1'b0;
            end else if (row == row_t'(v_sync_start + v_pulse - 1)) begin
                vsync <= 1'b1;
            end
        end
    end

    always_comb begin
        beam.col         = col;
        beam.row         = row;
        beam.col_visible = (col >= col_t'(h_start));
        beam.row_visible = (row < row_t'(v_visible));
        beam.line_end    = line_end;
    end

endmodule

// ==== logic/vga_pkg.sv ====
package vga_pkg;

    // external RAM byte address
    typedef logic [18:0] ram_adr_t;

    // raster positions
    typedef logic [10:0] col_t;
    typedef logic [9:0]  row_t;

    // palette index
    typedef logic [3:0]  color_idx_t;

    // packs as r1 r0 g1 g0 b1 b0
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef enum logic [1:0] {
        mode_off     = 2'd0,
        mode_text_40 = 2'd1,
        mode_gfx_640 = 2'd2,
        mode_gfx_320 = 2'd3
    } vga_mode_t;

    typedef struct packed {
        col_t col;
        row_t row;
        logic col_visible;
        logic row_visible;
        logic line_end;
    } beam_t;

    typedef struct packed {
        logic [3:0] adr;
        logic [7:0] dat;
        logic       we;
    } bus_req_t;

    typedef struct packed {
        ram_adr_t adr;
        logic     req;
    } ram_req_t;

endpackage
